// ==== exec_wb.f ====
+incdir+hw
+incdir+testbench
hw/exec_wb_pkg.sv
hw/wb_rec_if.sv
hw/exec_unit.sv
hw/wb_queue.sv
hw/reg_csr_file.sv
hw/exec_wb.sv
testbench/tb_exec_wb.sv

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_wb_config.svh"

module exec_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  exec_wb_pkg::op_e            cmd_op,
    input  logic [`REG_ADDR_WIDTH-1:0]  cmd_rd,
    input  logic [`CSR_ADDR_WIDTH-1:0]  cmd_csr_addr,
    input  logic [`XLEN-1:0]            cmd_a,
    input  logic [`XLEN-1:0]            cmd_b,
    input  logic [`XLEN-1:0]            cmd_pc,
    wb_rec_if.source                    out
);
    import exec_wb_pkg::*;

    wb_rec_t          next_rec;
    logic [`XLEN-1:0] alu_result;
    logic             accept;

    // take a new command when the output stage is free or draining.
    assign cmd_ready = ~rst & (~out.valid | out.ready);
    assign accept    = cmd_valid & cmd_ready;

    always_comb begin
        case (cmd_op)
            op_add:  alu_result = cmd_a + cmd_b;
            op_sub:  alu_result = cmd_a - cmd_b;
            op_and:  alu_result = cmd_a & cmd_b;
            op_or:   alu_result = cmd_a | cmd_b;
            op_xor:  alu_result = cmd_a ^ cmd_b;
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        next_rec.kind     = kind_gpr;
        next_rec.rd       = cmd_rd;
        next_rec.value    = alu_result;
        next_rec.csr_addr = cmd_csr_addr;
        next_rec.pc       = cmd_pc;
        next_rec.cause    = '0;
        case (cmd_op)
            op_csr_swap: begin
                // operand a becomes the new csr value.
                next_rec.kind  = kind_csr_swap;
                next_rec.value = cmd_a;
            end
            op_ecall: begin
                next_rec.kind  = kind_trap;
                next_rec.rd    = '0;
                next_rec.value = cmd_pc;
                next_rec.cause = `CAUSE_ECALL_M;
            end
            op_mret: begin
                next_rec.kind  = kind_ret;
                next_rec.rd    = '0;
                next_rec.value = cmd_pc;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    // loaded on each accepted command.
    always_ff @(posedge clk) begin
        if (accept) begin
            out.rec <= next_rec;
        end
    end

    // a stalled record must wait unchanged for the queue.
    a_rec_stable: assert property (
        @(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable(out.rec)
    );

endmodule

`default_nettype wire

// ==== hw/exec_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_wb_config.svh"

module exec_wb (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        commit_hold,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  exec_wb_pkg::op_e            cmd_op,
    input  logic [`REG_ADDR_WIDTH-1:0]  cmd_rd,
    input  logic [`CSR_ADDR_WIDTH-1:0]  cmd_csr_addr,
    input  logic [`XLEN-1:0]            cmd_a,
    input  logic [`XLEN-1:0]            cmd_b,
    input  logic [`XLEN-1:0]            cmd_pc,
    input  logic [`REG_ADDR_WIDTH-1:0]  raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0]  raddr2,
    output logic [`XLEN-1:0]            rdata1,
    output logic [`XLEN-1:0]            rdata2,
    input  logic [`CSR_ADDR_WIDTH-1:0]  csr_raddr,
    output logic [`XLEN-1:0]            csr_rdata,
    output logic                        retire_valid,
    output logic [`REG_ADDR_WIDTH-1:0]  retire_rd,
    output logic [`XLEN-1:0]            retire_data,
    output logic                        redirect_valid,
    output logic [`XLEN-1:0]            redirect_pc
);

    wb_rec_if ex_to_q ();
    wb_rec_if q_to_wb ();

    exec_unit u_exec (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_rd       (cmd_rd),
        .cmd_csr_addr (cmd_csr_addr),
        .cmd_a        (cmd_a),
        .cmd_b        (cmd_b),
        .cmd_pc       (cmd_pc),
        .out          (ex_to_q.source)
    );

    // lets execution run ahead while commit is held.
    wb_queue #(
        .depth (`WB_QUEUE_DEPTH)
    ) u_queue (
        .clk (clk),
        .rst (rst),
        .in  (ex_to_q.sink),
        .out (q_to_wb.source)
    );

    reg_csr_file u_rf (
        .clk            (clk),
        .rst            (rst),
        .commit_hold    (commit_hold),
        .in             (q_to_wb.sink),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== hw/exec_wb_config.svh ====
`ifndef EXEC_WB_CONFIG_SVH
`define EXEC_WB_CONFIG_SVH

// datapath widths.
`define XLEN            32
`define REG_ADDR_WIDTH  5
`define CSR_ADDR_WIDTH  12

// machine CSR numbers.
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12

// read-only identity words.
`define MVENDORID_VALUE 32'h0000_0000
`define MARCHID_VALUE   32'h0000_0017

// mstatus comes out of reset in machine mode with mpp = 3.
`define MSTATUS_RESET_VALUE 32'h0000_1800
`define MPP_MACHINE     2'b11

`define CAUSE_ECALL_M   32'd11

`define WB_QUEUE_DEPTH  4

`endif

// ==== hw/exec_wb_pkg.sv ====
`default_nettype none

`include "exec_wb_config.svh"

package exec_wb_pkg;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_csr_swap,
        op_ecall,
        op_mret
    } op_e;

    // what the commit stage does with a record.
    typedef enum logic [1:0] {
        kind_gpr,
        kind_csr_swap,
        kind_trap,
        kind_ret
    } kind_e;

    typedef struct packed {
        kind_e                       kind;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`XLEN-1:0]            value;
        logic [`CSR_ADDR_WIDTH-1:0]  csr_addr;
        logic [`XLEN-1:0]            pc;
        logic [`XLEN-1:0]            cause;
    } wb_rec_t;

    typedef struct packed {
        logic [31:13] rsvd_hi;
        logic [1:0]   mpp;
        logic [10:8]  rsvd_mid;
        logic         mpie;
        logic [6:4]   rsvd_lo;
        logic         mie;
        logic [2:0]   rsvd_wpri;
    } mstatus_t;

    // raw view for csr access, field view for trap entry and return.
    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_t         f;
    } mstatus_u;

endpackage

`default_nettype wire

// ==== hw/reg_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_wb_config.svh"

module reg_csr_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        commit_hold,
    wb_rec_if.sink                      in,
    input  logic [`REG_ADDR_WIDTH-1:0]  raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0]  raddr2,
    output logic [`XLEN-1:0]            rdata1,
    output logic [`XLEN-1:0]            rdata2,
    input  logic [`CSR_ADDR_WIDTH-1:0]  csr_raddr,
    output logic [`XLEN-1:0]            csr_rdata,
    output logic                        retire_valid,
    output logic [`REG_ADDR_WIDTH-1:0]  retire_rd,
    output logic [`XLEN-1:0]            retire_data,
    output logic                        redirect_valid,
    output logic [`XLEN-1:0]            redirect_pc
);
    import exec_wb_pkg::*;

    localparam int num_regs = 2 ** `REG_ADDR_WIDTH;

    logic [`XLEN-1:0] gpr [num_regs];
    mstatus_u         mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;

    logic             take;
    logic             rd_we;
    logic             is_redirect;
    logic [`XLEN-1:0] old_csr;
    logic [`XLEN-1:0] rd_wdata;
    logic [`XLEN-1:0] next_pc;

    // unknown addresses read as zero.
    function automatic logic [`XLEN-1:0] csr_read(input logic [`CSR_ADDR_WIDTH-1:0] addr);
        case (addr)
            `CSR_MSTATUS:   return mstatus.raw;
            `CSR_MTVEC:     return mtvec;
            `CSR_MEPC:      return mepc;
            `CSR_MCAUSE:    return mcause;
            `CSR_MVENDORID: return `MVENDORID_VALUE;
            `CSR_MARCHID:   return `MARCHID_VALUE;
            default:        return '0;
        endcase
    endfunction

    assign in.ready = ~rst & ~commit_hold;
    assign take     = in.valid & in.ready;

    always_comb begin
        csr_rdata = csr_read(csr_raddr);
    end

    always_comb begin
        old_csr = csr_read(in.rec.csr_addr);
    end

    assign rd_we = take && (in.rec.kind == kind_gpr || in.rec.kind == kind_csr_swap)
                   && (in.rec.rd != '0);
    assign rd_wdata    = (in.rec.kind == kind_csr_swap) ? old_csr : in.rec.value;
    assign is_redirect = (in.rec.kind == kind_trap) || (in.rec.kind == kind_ret);
    assign next_pc     = (in.rec.kind == kind_trap) ? mtvec : mepc;

    always_ff @(posedge clk) begin
        if (rd_we) begin
            gpr[in.rec.rd] <= rd_wdata;
        end
    end

    // x0 is never written, so force it here.
    assign rdata1 = (raddr1 == '0) ? '0 : gpr[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : gpr[raddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus.raw <= `MSTATUS_RESET_VALUE;
            mtvec       <= '0;
            mepc        <= '0;
            mcause      <= '0;
        end else if (take) begin
            case (in.rec.kind)
                kind_csr_swap: begin
                    // identity registers ignore writes.
                    case (in.rec.csr_addr)
                        `CSR_MSTATUS: mstatus.raw <= in.rec.value;
                        `CSR_MTVEC:   mtvec       <= in.rec.value;
                        `CSR_MEPC:    mepc        <= in.rec.value;
                        `CSR_MCAUSE:  mcause      <= in.rec.value;
                        default: begin
                        end
                    endcase
                end
                kind_trap: begin
                    mepc           <= in.rec.pc;
                    mcause         <= in.rec.cause;
                    mstatus.f.mpie <= mstatus.f.mie;
                    mstatus.f.mie  <= 1'b0;
                    mstatus.f.mpp  <= `MPP_MACHINE;
                end
                kind_ret: begin
                    mstatus.f.mie  <= mstatus.f.mpie;
                    mstatus.f.mpie <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            retire_valid   <= take;
            redirect_valid <= take & is_redirect;
        end
    end

    // retire trace payload.
    always_ff @(posedge clk) begin
        if (take) begin
            retire_rd   <= in.rec.rd;
            retire_data <= rd_we ? rd_wdata : '0;
            redirect_pc <= next_pc;
        end
    end

    a_redirect_on_retire: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid |-> retire_valid
    );

endmodule

`default_nettype wire

// ==== hw/wb_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_wb_config.svh"

module wb_queue #(
    parameter int depth = `WB_QUEUE_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    wb_rec_if.sink   in,
    wb_rec_if.source out
);
    import exec_wb_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    wb_rec_t           mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in.ready  = (count != cnt_w'(depth));
    assign out.valid = (count != '0);
    assign out.rec   = mem[rd_ptr];

    assign push = in.valid & in.ready;
    assign pop  = out.valid & out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count alone.
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        (count == cnt_w'(depth)) |-> !push
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        (count == '0) |-> !pop
    );

endmodule

`default_nettype wire

// ==== hw/wb_rec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one writeback record with a valid/ready handshake.
interface wb_rec_if;
    import exec_wb_pkg::*;

    logic    valid;
    logic    ready;
    wb_rec_t rec;

    // producer side.
    modport source (
        output valid,
        output rec,
        input  ready
    );

    // consumer side.
    modport sink (
        input  valid,
        input  rec,
        output ready
    );

endinterface

`default_nettype wire

// ==== testbench/tb_exec_wb_table.svh ====
`ifndef TB_EXEC_WB_TABLE_SVH
`define TB_EXEC_WB_TABLE_SVH

// each row holds op, rd, csr, a, b and pc, then expected retire_rd, retire_data,
// redirect flag, redirect_pc and csr_rdata at the row's csr after commit.
localparam int num_rows = 16;

op_e                        tbl_op        [num_rows];
logic [`REG_ADDR_WIDTH-1:0] tbl_rd        [num_rows];
logic [`CSR_ADDR_WIDTH-1:0] tbl_csr       [num_rows];
logic [`XLEN-1:0]           tbl_a         [num_rows];
logic [`XLEN-1:0]           tbl_b         [num_rows];
logic [`XLEN-1:0]           tbl_pc        [num_rows];
logic [`REG_ADDR_WIDTH-1:0] tbl_exp_rd    [num_rows];
logic [`XLEN-1:0]           tbl_exp_data  [num_rows];
logic                       tbl_exp_redir [num_rows];
logic [`XLEN-1:0]           tbl_exp_pc    [num_rows];
logic [`XLEN-1:0]           tbl_exp_csr   [num_rows];

task automatic set_row(
    input int                         i,
    input op_e                        op,
    input logic [`REG_ADDR_WIDTH-1:0] rd,
    input logic [`CSR_ADDR_WIDTH-1:0] csr,
    input logic [`XLEN-1:0]           a,
    input logic [`XLEN-1:0]           b,
    input logic [`XLEN-1:0]           pc,
    input logic [`REG_ADDR_WIDTH-1:0] exp_rd,
    input logic [`XLEN-1:0]           exp_data,
    input logic                       exp_redir,
    input logic [`XLEN-1:0]           exp_pc,
    input logic [`XLEN-1:0]           exp_csr
);
    tbl_op[i]        = op;
    tbl_rd[i]        = rd;
    tbl_csr[i]       = csr;
    tbl_a[i]         = a;
    tbl_b[i]         = b;
    tbl_pc[i]        = pc;
    tbl_exp_rd[i]    = exp_rd;
    tbl_exp_data[i]  = exp_data;
    tbl_exp_redir[i] = exp_redir;
    tbl_exp_pc[i]    = exp_pc;
    tbl_exp_csr[i]   = exp_csr;
endtask

// csrs end each pass at their reset values, so a replay retires the same way.
task automatic load_table();
    set_row( 0, op_add,      5'd1,  `CSR_MVENDORID, 32'h0000_1234, 32'h0000_0f0f, 32'h0,
             5'd1,  32'h0000_2143, 1'b0, 32'h0, 32'h0000_0000);
    set_row( 1, op_sub,      5'd2,  `CSR_MARCHID, 32'h1000_0000, 32'h0000_0001, 32'h0,
             5'd2,  32'h0fff_ffff, 1'b0, 32'h0, 32'h0000_0017);
    set_row( 2, op_and,      5'd3,  `CSR_MVENDORID, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0,
             5'd3,  32'hf000_f000, 1'b0, 32'h0, 32'h0000_0000);
    set_row( 3, op_or,       5'd4,  `CSR_MVENDORID, 32'h00ff_0000, 32'h0000_00ff, 32'h0,
             5'd4,  32'h00ff_00ff, 1'b0, 32'h0, 32'h0000_0000);
    set_row( 4, op_xor,      5'd5,  `CSR_MARCHID, 32'haaaa_5555, 32'hffff_0000, 32'h0,
             5'd5,  32'h5555_5555, 1'b0, 32'h0, 32'h0000_0017);
    // write to x0 retires with zero data.
    set_row( 5, op_add,      5'd0,  `CSR_MVENDORID, 32'h0000_0001, 32'h0000_0002, 32'h0,
             5'd0,  32'h0000_0000, 1'b0, 32'h0, 32'h0000_0000);
    set_row( 6, op_csr_swap, 5'd6,  `CSR_MTVEC, 32'h0000_0100, 32'h0, 32'h0,
             5'd6,  32'h0000_0000, 1'b0, 32'h0, 32'h0000_0100);
    set_row( 7, op_csr_swap, 5'd7,  `CSR_MSTATUS, 32'h0000_1808, 32'h0, 32'h0,
             5'd7,  32'h0000_1800, 1'b0, 32'h0, 32'h0000_1808);
    set_row( 8, op_csr_swap, 5'd8,  `CSR_MARCHID, 32'hdead_beef, 32'h0, 32'h0,
             5'd8,  32'h0000_0017, 1'b0, 32'h0, 32'h0000_0017);
    set_row( 9, op_ecall,    5'd0,  `CSR_MSTATUS, 32'h0, 32'h0, 32'h0000_0040,
             5'd0,  32'h0000_0000, 1'b1, 32'h0000_0100, 32'h0000_1880);
    set_row(10, op_mret,     5'd0,  `CSR_MSTATUS, 32'h0, 32'h0, 32'h0000_0080,
             5'd0,  32'h0000_0000, 1'b1, 32'h0000_0040, 32'h0000_1888);
    set_row(11, op_csr_swap, 5'd9,  `CSR_MCAUSE, 32'h0, 32'h0, 32'h0,
             5'd9,  32'h0000_000b, 1'b0, 32'h0, 32'h0000_0000);
    set_row(12, op_csr_swap, 5'd10, `CSR_MEPC, 32'h0, 32'h0, 32'h0,
             5'd10, 32'h0000_0040, 1'b0, 32'h0, 32'h0000_0000);
    set_row(13, op_csr_swap, 5'd11, `CSR_MTVEC, 32'h0, 32'h0, 32'h0,
             5'd11, 32'h0000_0100, 1'b0, 32'h0, 32'h0000_0000);
    set_row(14, op_csr_swap, 5'd12, `CSR_MSTATUS, 32'h0000_1800, 32'h0, 32'h0,
             5'd12, 32'h0000_1888, 1'b0, 32'h0, 32'h0000_1800);
    set_row(15, op_xor,      5'd1,  `CSR_MVENDORID, 32'h0000_2143, 32'hffff_ffff, 32'h0,
             5'd1,  32'hffff_debc, 1'b0, 32'h0, 32'h0000_0000);
endtask

`endif

// ==== testbench/tb_exec_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_wb_config.svh"

module tb_exec_wb;
    import exec_wb_pkg::*;

    `include "tb_exec_wb_table.svh"

    // reset, two passes with their register checks, and some margin.
    localparam int cycle_limit = 8 + 2 * (20 * num_rows + 32) + 16;

    logic                        clk;
    logic                        rst;
    logic                        commit_hold;
    logic                        cmd_valid;
    logic                        cmd_ready;
    op_e                         cmd_op;
    logic [`REG_ADDR_WIDTH-1:0]  cmd_rd;
    logic [`CSR_ADDR_WIDTH-1:0]  cmd_csr_addr;
    logic [`XLEN-1:0]            cmd_a;
    logic [`XLEN-1:0]            cmd_b;
    logic [`XLEN-1:0]            cmd_pc;
    logic [`REG_ADDR_WIDTH-1:0]  raddr1;
    logic [`REG_ADDR_WIDTH-1:0]  raddr2;
    logic [`XLEN-1:0]            rdata1;
    logic [`XLEN-1:0]            rdata2;
    logic [`CSR_ADDR_WIDTH-1:0]  csr_raddr;
    logic [`XLEN-1:0]            csr_rdata;
    logic                        retire_valid;
    logic [`REG_ADDR_WIDTH-1:0]  retire_rd;
    logic [`XLEN-1:0]            retire_data;
    logic                        redirect_valid;
    logic [`XLEN-1:0]            redirect_pc;

    logic                        hold_random;
    logic                        probe_on;
    logic [`CSR_ADDR_WIDTH-1:0]  probe_addr;
    logic [`XLEN-1:0]            reg_model [32];
    logic                        reg_written [32];
    int                          ret_count;
    int                          cycle_count;
    int                          value_errors;
    int                          other_errors;

    exec_wb dut0 (
        .clk            (clk),
        .rst            (rst),
        .commit_hold    (commit_hold),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_op         (cmd_op),
        .cmd_rd         (cmd_rd),
        .cmd_csr_addr   (cmd_csr_addr),
        .cmd_a          (cmd_a),
        .cmd_b          (cmd_b),
        .cmd_pc         (cmd_pc),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // read back whatever just retired.
    assign raddr1    = (retire_valid === 1'b1) ? retire_rd : '0;
    assign csr_raddr = probe_on ? probe_addr : tbl_csr[ret_count % num_rows];

    always #10 clk = ~clk;

    // debug halts, random only in the second pass.
    initial begin
        void'($urandom(32'h1bbf_c6b0));
        forever begin
            @(posedge clk);
            #2;
            commit_hold = hold_random ? ($urandom % 2 == 1) : 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d retires seen", cycle_count, ret_count);
            other_errors++;
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic send_row(input int i);
        logic taken;
        cmd_valid    = 1'b1;
        cmd_op       = tbl_op[i];
        cmd_rd       = tbl_rd[i];
        cmd_csr_addr = tbl_csr[i];
        cmd_a        = tbl_a[i];
        cmd_b        = tbl_b[i];
        cmd_pc       = tbl_pc[i];
        taken        = 1'b0;
        // cmd_ready only depends on registered state.
        while (!taken) begin
            @(negedge clk);
            taken = cmd_ready;
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b0;
    endtask

    task automatic check_retire(input int row);
        if (retire_rd !== tbl_exp_rd[row]) begin
            $display("Error: retire_rd row %0d got %h expected %h",
                     row, retire_rd, tbl_exp_rd[row]);
            value_errors++;
        end
        if (retire_data !== tbl_exp_data[row]) begin
            $display("Error: retire_data row %0d got %h expected %h",
                     row, retire_data, tbl_exp_data[row]);
            value_errors++;
        end
        if (redirect_valid !== tbl_exp_redir[row]) begin
            $display("Error: redirect_valid row %0d got %h expected %h",
                     row, redirect_valid, tbl_exp_redir[row]);
            value_errors++;
        end
        if (tbl_exp_redir[row] && redirect_pc !== tbl_exp_pc[row]) begin
            $display("Error: redirect_pc row %0d got %h expected %h",
                     row, redirect_pc, tbl_exp_pc[row]);
            value_errors++;
        end
        if (rdata1 !== tbl_exp_data[row]) begin
            $display("Error: rdata1 row %0d got %h expected %h",
                     row, rdata1, tbl_exp_data[row]);
            value_errors++;
        end
        if (csr_rdata !== tbl_exp_csr[row]) begin
            $display("Error: csr_rdata row %0d got %h expected %h",
                     row, csr_rdata, tbl_exp_csr[row]);
            value_errors++;
        end
    endtask

    task automatic check_csr(input logic [`CSR_ADDR_WIDTH-1:0] addr,
                             input logic [`XLEN-1:0] exp);
        @(posedge clk);
        #2;
        probe_addr = addr;
        @(negedge clk);
        if (csr_rdata !== exp) begin
            $display("Error: csr_rdata at %h got %h expected %h", addr, csr_rdata, exp);
            value_errors++;
        end
    endtask

    // last write to each rd wins.
    task automatic build_reg_model();
        for (int r = 0; r < 32; r++) begin
            reg_written[r] = 1'b0;
            reg_model[r]   = '0;
        end
        for (int i = 0; i < num_rows; i++) begin
            if (tbl_exp_rd[i] != '0) begin
                reg_model[tbl_exp_rd[i]]   = tbl_exp_data[i];
                reg_written[tbl_exp_rd[i]] = 1'b1;
            end
        end
    endtask

    task automatic check_regs(input int pass);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #2;
            raddr2 = 5'(r);
            @(negedge clk);
            if ((r == 0 || reg_written[r]) && rdata2 !== reg_model[r]) begin
                $display("Error: rdata2 x%0d pass %0d got %h expected %h",
                         r, pass, rdata2, reg_model[r]);
                value_errors++;
            end
        end
    endtask

    task automatic wait_retires(input int target);
        while (ret_count < target) begin
            @(negedge clk);
        end
    endtask

    // monitor samples mid-cycle.
    initial begin
        forever begin
            @(negedge clk);
            if (rst) begin
                if (retire_valid !== 1'b0 || redirect_valid !== 1'b0) begin
                    $display("Error: retire_valid %h redirect_valid %h in reset expected 0",
                             retire_valid, redirect_valid);
                    value_errors++;
                end
                if (cmd_ready !== 1'b0) begin
                    $display("Error: cmd_ready in reset got %h expected 0", cmd_ready);
                    value_errors++;
                end
            end else if (retire_valid) begin
                if (ret_count >= 2 * num_rows) begin
                    $display("a retire arrived after the whole table had retired");
                    other_errors++;
                end else begin
                    check_retire(ret_count % num_rows);
                end
                ret_count++;
            end else if (redirect_valid) begin
                $display("a redirect appeared without a retire");
                other_errors++;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        commit_hold  = 1'b0;
        hold_random  = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = op_add;
        cmd_rd       = '0;
        cmd_csr_addr = '0;
        cmd_a        = '0;
        cmd_b        = '0;
        cmd_pc       = '0;
        raddr2       = '0;
        probe_on     = 1'b1;
        probe_addr   = `CSR_MSTATUS;
        ret_count    = 0;
        cycle_count  = 0;
        value_errors = 0;
        other_errors = 0;
        load_table();
        build_reg_model();

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        check_csr(`CSR_MSTATUS, 32'h0000_1800);
        check_csr(`CSR_MVENDORID, `MVENDORID_VALUE);
        check_csr(`CSR_MARCHID, `MARCHID_VALUE);
        probe_on = 1'b0;

        // first pass with commit never held.
        @(posedge clk);
        #2;
        for (int i = 0; i < num_rows; i++) begin
            send_row(i);
        end
        wait_retires(num_rows);
        check_regs(1);

        // second pass under random debug halts.
        hold_random = 1'b1;
        @(posedge clk);
        #2;
        for (int i = 0; i < num_rows; i++) begin
            send_row(i);
        end
        wait_retires(2 * num_rows);
        hold_random = 1'b0;
        check_regs(2);

        // catch any extra retires.
        repeat (10) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
